// File: common/snappy_pkg.sv
//######################################################################
// shared widths, data types and enums for the byte-serial decompressor
// referenced by scoped names from the RTL and the testbench
//######################################################################
`default_nettype none

package snappy_pkg;

	localparam int WORD_BYTES = 8;	// bytes per bus word

	typedef logic [WORD_BYTES*8-1:0] word_t;
	typedef logic [WORD_BYTES-1:0]   keep_t;	// one valid flag per lane
	typedef logic [7:0]              byte_t;
	typedef logic [31:0]             len_t;
	typedef logic [15:0]             offset_t;
	typedef logic [6:0]              copy_len_t;	// runs of up to 64

	// low two bits of every tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY1   = 2'b01,
		TAG_COPY2   = 2'b10,
		TAG_COPY4   = 2'b11	// not produced by a legal stream here
	} tag_e;

	typedef enum logic {
		CMD_LIT  = 1'b0,
		CMD_COPY = 1'b1
	} cmd_e;

	typedef enum logic [2:0] {
		PS_TAG, PS_LIT, PS_OFF_LO, PS_OFF_HI, PS_DONE
	} parse_state_e;

endpackage

`default_nettype wire

// File: common/copy_cmd_if.sv
//######################################################################
// command link from the token parser to the history copier
// a command moves on any edge with valid and ready both high
//######################################################################
`timescale 1ns/100ps
`default_nettype none

interface copy_cmd_if;

	logic                  valid;
	snappy_pkg::cmd_e      kind;	// literal byte or back-reference
	snappy_pkg::byte_t     lit;
	snappy_pkg::offset_t   offset;	// distance back into history
	snappy_pkg::copy_len_t length;
	logic                  ready;

	modport source (
		output valid, kind, lit, offset, length,
		input  ready
	);

	modport sink (
		input  valid, kind, lit, offset, length,
		output ready
	);

endinterface

`default_nettype wire

// File: rtl/data_fifo.sv
//######################################################################
// synchronous word FIFO between the input bus and the token parser
// write side ready drops two entries short of full, read side is
// a plain valid/ready port showing the head entry
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module data_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                clk,
	input  wire                rst_i,
	input  snappy_pkg::word_t  wr_data_i,
	input  wire                wr_valid_i,
	output logic               wr_ready_o,
	output snappy_pkg::word_t  rd_data_o,
	output logic               rd_valid_o,
	input  wire                rd_ready_i
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	snappy_pkg::word_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  fill;
	logic              almost_full;
	logic              empty;
	logic              wr_en;
	logic              rd_en;

	assign almost_full = (fill >= CNT_W'(FIFO_DEPTH - 2));	// room for words in flight
	assign empty       = (fill == '0);
	assign wr_ready_o  = ~almost_full;
	assign rd_valid_o  = ~empty;
	assign rd_data_o   = mem[rd_ptr];
	assign wr_en       = wr_valid_i & wr_ready_o;
	assign rd_en       = rd_ready_i & rd_valid_o;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;	// both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data_i;
	end

endmodule

`default_nettype wire

// File: parser/token_parser.sv
//######################################################################
// splits FIFO words into bytes, low byte first, and decodes the tag
// stream into literal and copy commands for the history copier
// bytes past the compressed length are dropped with their word
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module token_parser (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                start_i,
	input  snappy_pkg::len_t   compression_length_i,
	input  snappy_pkg::word_t  word_i,
	input  wire                word_valid_i,
	output logic               word_ready_o,
	copy_cmd_if.source         cmd_o
);

	localparam int BI_W = $clog2(snappy_pkg::WORD_BYTES);

	snappy_pkg::parse_state_e state;
	snappy_pkg::parse_state_e after_state;
	snappy_pkg::word_t        cur_word;
	logic [BI_W-1:0]          byte_idx;
	logic                     have_word;
	snappy_pkg::len_t         rem_cnt;	// compressed bytes still to parse
	snappy_pkg::byte_t        cur_byte;
	logic                     byte_avail;
	logic                     last_byte;
	logic                     take;
	snappy_pkg::copy_len_t    lit_cnt;
	snappy_pkg::copy_len_t    len_q;
	snappy_pkg::offset_t      off_q;
	logic                     is_copy2;
	logic                     copy_pend;	// copy command waiting on the copier

	assign cur_byte     = cur_word[byte_idx*8 +: 8];
	assign byte_avail   = have_word & (rem_cnt != '0);
	assign last_byte    = (rem_cnt == snappy_pkg::len_t'(1));
	assign after_state  = last_byte ? snappy_pkg::PS_DONE : snappy_pkg::PS_TAG;
	assign word_ready_o = ~have_word & (rem_cnt != '0);	// no fetch past the page

	// literal bytes pass straight through, copies come from the held registers
	assign cmd_o.valid  = copy_pend | ((state == snappy_pkg::PS_LIT) & byte_avail);
	assign cmd_o.kind   = copy_pend ? snappy_pkg::CMD_COPY : snappy_pkg::CMD_LIT;
	assign cmd_o.lit    = cur_byte;
	assign cmd_o.offset = off_q;
	assign cmd_o.length = copy_pend ? len_q : snappy_pkg::copy_len_t'(1);

	always_comb begin
		take = 1'b0;
		if (byte_avail && !copy_pend) begin
			case (state)
				snappy_pkg::PS_TAG,
				snappy_pkg::PS_OFF_LO,
				snappy_pkg::PS_OFF_HI: take = 1'b1;
				snappy_pkg::PS_LIT:    take = cmd_o.ready;	// byte leaves as CMD_LIT
				default:               take = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state     <= snappy_pkg::PS_DONE;
			have_word <= 1'b0;
			byte_idx  <= '0;
			rem_cnt   <= '0;
			lit_cnt   <= '0;
			is_copy2  <= 1'b0;
			copy_pend <= 1'b0;
		end else if (start_i) begin
			state     <= snappy_pkg::PS_TAG;
			have_word <= 1'b0;
			byte_idx  <= '0;
			rem_cnt   <= compression_length_i;
			copy_pend <= 1'b0;
		end else begin
			if (word_valid_i && word_ready_o) begin
				have_word <= 1'b1;
				byte_idx  <= '0;
			end
			if (copy_pend && cmd_o.ready)
				copy_pend <= 1'b0;
			if (take) begin
				rem_cnt <= rem_cnt - 1'b1;
				// last lane or last real byte releases the word
				if (byte_idx == BI_W'(snappy_pkg::WORD_BYTES - 1) || last_byte) begin
					have_word <= 1'b0;
					byte_idx  <= '0;
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
				case (state)
					snappy_pkg::PS_TAG: begin
						case (snappy_pkg::tag_e'(cur_byte[1:0]))
							snappy_pkg::TAG_LITERAL: begin
								lit_cnt <= snappy_pkg::copy_len_t'(cur_byte[7:2]) + 1'b1;
								state   <= snappy_pkg::PS_LIT;
							end
							snappy_pkg::TAG_COPY1: begin
								is_copy2 <= 1'b0;
								state    <= snappy_pkg::PS_OFF_LO;
							end
							snappy_pkg::TAG_COPY2: begin
								is_copy2 <= 1'b1;
								state    <= snappy_pkg::PS_OFF_LO;
							end
							default: state <= after_state;	// COPY4 skipped
						endcase
					end
					snappy_pkg::PS_LIT: begin
						lit_cnt <= lit_cnt - 1'b1;
						if (lit_cnt == snappy_pkg::copy_len_t'(1))
							state <= after_state;
					end
					snappy_pkg::PS_OFF_LO: begin
						if (is_copy2) begin
							state <= snappy_pkg::PS_OFF_HI;
						end else begin
							copy_pend <= 1'b1;
							state     <= after_state;
						end
					end
					snappy_pkg::PS_OFF_HI: begin
						copy_pend <= 1'b1;
						state     <= after_state;
					end
					default: state <= state;
				endcase
			end
		end
	end

	// current word, copy length and offset
	always_ff @(posedge clk) begin
		if (word_valid_i && word_ready_o)
			cur_word <= word_i;
		if (take) begin
			if (state == snappy_pkg::PS_TAG) begin
				if (cur_byte[1:0] == snappy_pkg::TAG_COPY1) begin
					len_q        <= snappy_pkg::copy_len_t'(cur_byte[4:2]) + 7'd4;
					off_q[15:8]  <= {5'b0, cur_byte[7:5]};
				end else begin
					len_q <= snappy_pkg::copy_len_t'(cur_byte[7:2]) + 1'b1;
				end
			end
			if (state == snappy_pkg::PS_OFF_LO)
				off_q[7:0] <= cur_byte;
			if (state == snappy_pkg::PS_OFF_HI)
				off_q[15:8] <= cur_byte;	// high byte of a two-byte offset
		end
	end

endmodule

`default_nettype wire

// File: history/history_copier.sv
//######################################################################
// history window that turns parser commands into the output bytes
// every byte sent is also written into the ring, so copies can read
// back any of the last HIST_BYTES bytes, overlapping copies included
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module history_copier #(
	parameter int HIST_BYTES = 4096	// power of two so the ring wraps on its own
) (
	input  wire                clk,
	input  wire                rst_i,
	copy_cmd_if.sink           cmd_i,
	output snappy_pkg::byte_t  byte_o,
	output logic               byte_valid_o,
	input  wire                byte_ready_i
);

	localparam int ADDR_W = $clog2(HIST_BYTES);

	snappy_pkg::byte_t     hist [HIST_BYTES];
	logic [ADDR_W-1:0]     wr_ptr;
	logic [ADDR_W-1:0]     rd_ptr;
	logic                  active;	// inside a multi-byte copy
	snappy_pkg::copy_len_t rem_q;
	snappy_pkg::copy_len_t remaining;
	logic                  is_copy;
	logic                  step;

	always_comb begin
		is_copy   = (cmd_i.kind == snappy_pkg::CMD_COPY);
		remaining = active ? rem_q : cmd_i.length;
		rd_ptr    = wr_ptr - ADDR_W'(cmd_i.offset);
		step      = cmd_i.valid & byte_ready_i;
	end

	assign byte_o       = is_copy ? hist[rd_ptr] : cmd_i.lit;
	assign byte_valid_o = cmd_i.valid;
	// copy command is released only on its final byte
	assign cmd_i.ready  = byte_ready_i & (~is_copy | (remaining == snappy_pkg::copy_len_t'(1)));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			active <= 1'b0;
			rem_q  <= '0;
		end else if (step) begin
			wr_ptr <= wr_ptr + 1'b1;
			if (is_copy) begin
				if (remaining == snappy_pkg::copy_len_t'(1)) begin
					active <= 1'b0;
				end else begin
					active <= 1'b1;
					rem_q  <= remaining - 1'b1;
				end
			end
		end
	end

	// written byte is visible to a copy reading one back on the next cycle
	always_ff @(posedge clk) begin
		if (step)
			hist[wr_ptr] <= byte_o;
	end

endmodule

`default_nettype wire

// File: rtl/output_packer.sv
//######################################################################
// gathers output bytes into bus words, lane 0 first
// counts down the uncompressed length to flag the final word and
// pulses done once that word has been taken
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module output_packer (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                start_i,
	input  snappy_pkg::len_t   decompression_length_i,
	input  snappy_pkg::byte_t  byte_i,
	input  wire                byte_valid_i,
	output logic               byte_ready_o,
	output snappy_pkg::word_t  data_o,
	output snappy_pkg::keep_t  byte_valid_o,
	output logic               valid_o,
	input  wire                ready_i,
	output logic               last_o,
	output logic               done_o
);

	localparam int LANE_W = $clog2(snappy_pkg::WORD_BYTES);

	logic [LANE_W-1:0] lane;
	snappy_pkg::len_t  rem_cnt;	// bytes left in this page
	logic              accept;
	logic              word_end;

	assign byte_ready_o = ~valid_o & (rem_cnt != '0);
	assign accept       = byte_valid_i & byte_ready_o;
	assign word_end     = (lane == LANE_W'(snappy_pkg::WORD_BYTES - 1)) |
	                      (rem_cnt == snappy_pkg::len_t'(1));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			lane         <= '0;
			rem_cnt      <= '0;
			byte_valid_o <= '0;
			valid_o      <= 1'b0;
			last_o       <= 1'b0;
			done_o       <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				lane         <= '0;
				rem_cnt      <= decompression_length_i;
				byte_valid_o <= '0;
			end else if (accept) begin
				byte_valid_o[lane] <= 1'b1;
				rem_cnt            <= rem_cnt - 1'b1;
				lane               <= word_end ? '0 : lane + 1'b1;
				if (word_end) begin
					valid_o <= 1'b1;
					last_o  <= (rem_cnt == snappy_pkg::len_t'(1));
				end
			end
			if (valid_o && ready_i) begin
				valid_o      <= 1'b0;
				last_o       <= 1'b0;
				byte_valid_o <= '0;
				done_o       <= last_o;	// one cycle after the final handshake
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			data_o[lane*8 +: 8] <= byte_i;
	end

endmodule

`default_nettype wire

// File: rtl/decompressor.sv
//######################################################################
// top level of the byte-serial decompressor
// input FIFO, token parser, history copier and output packer in a row
// start_i loads the page lengths, done_o marks the end of a page
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module decompressor #(
	parameter int FIFO_DEPTH = 16,
	parameter int HIST_BYTES = 4096
) (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                start_i,
	input  snappy_pkg::len_t   compression_length_i,
	input  snappy_pkg::len_t   decompression_length_i,
	input  snappy_pkg::word_t  data_i,
	input  wire                valid_i,
	output logic               ready_o,	// FIFO not almost full
	output snappy_pkg::word_t  data_o,
	output snappy_pkg::keep_t  byte_valid_o,
	output logic               valid_o,
	input  wire                ready_i,
	output logic               last_o,
	output logic               done_o
);

	snappy_pkg::word_t fifo_data;
	logic              fifo_valid;
	logic              parser_ready;
	snappy_pkg::byte_t out_byte;
	logic              out_valid;
	logic              out_ready;

	copy_cmd_if u_copy_cmd_if ();

	data_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_data_fifo (
		.clk        (clk),
		.rst_i      (rst_i),
		.wr_data_i  (data_i),
		.wr_valid_i (valid_i),
		.wr_ready_o (ready_o),
		.rd_data_o  (fifo_data),
		.rd_valid_o (fifo_valid),
		.rd_ready_i (parser_ready)
	);

	token_parser u_token_parser (
		.clk                  (clk),
		.rst_i                (rst_i),
		.start_i              (start_i),
		.compression_length_i (compression_length_i),
		.word_i               (fifo_data),
		.word_valid_i         (fifo_valid),
		.word_ready_o         (parser_ready),
		.cmd_o                (u_copy_cmd_if.source)
	);

	history_copier #(
		.HIST_BYTES (HIST_BYTES)
	) u_history_copier (
		.clk          (clk),
		.rst_i        (rst_i),
		.cmd_i        (u_copy_cmd_if.sink),
		.byte_o       (out_byte),
		.byte_valid_o (out_valid),
		.byte_ready_i (out_ready)
	);

	output_packer u_output_packer (
		.clk                    (clk),
		.rst_i                  (rst_i),
		.start_i                (start_i),
		.decompression_length_i (decompression_length_i),
		.byte_i                 (out_byte),
		.byte_valid_i           (out_valid),
		.byte_ready_o           (out_ready),
		.data_o                 (data_o),
		.byte_valid_o           (byte_valid_o),
		.valid_o                (valid_o),
		.ready_i                (ready_i),
		.last_o                 (last_o),
		.done_o                 (done_o)
	);

endmodule

`default_nettype wire

// File: sim/decompressor_asserts.sv
//######################################################################
// protocol checks on the decompressor ports and internal state
// bound into the decompressor top level from the testbench
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module decompressor_asserts #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                            clk,
	input  wire                            rst_i,
	input  wire                            in_ready_i,
	input  wire                            out_valid_i,
	input  wire                            out_ready_i,
	input  snappy_pkg::word_t              out_data_i,
	input  snappy_pkg::keep_t              out_keep_i,
	input  wire                            out_last_i,
	input  wire                            done_i,
	input  wire [$clog2(FIFO_DEPTH+1)-1:0] fifo_fill_i,
	input  snappy_pkg::parse_state_e       parser_state_i
);

	int fail_cnt = 0;

	// word frozen while the sink stalls
	hold_while_stalled: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i) &&
		$stable(out_keep_i) && $stable(out_last_i))
	else begin
		$error("output word changed while ready_i was low");
		fail_cnt++;
	end

	no_ready_when_full: assert property (@(posedge clk) disable iff (rst_i)
		!(fifo_fill_i == FIFO_DEPTH && in_ready_i))
	else begin
		$error("ready_o high with the input FIFO full");
		fail_cnt++;
	end

	last_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
		out_last_i |-> out_valid_i)
	else begin
		$error("last_o high without valid_o");
		fail_cnt++;
	end

	done_after_last: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i && out_ready_i && out_last_i |=> done_i)
	else begin
		$error("done_o missing after the final word");
		fail_cnt++;
	end

	done_only_after_last: assert property (@(posedge clk) disable iff (rst_i)
		done_i |-> $past(out_valid_i && out_ready_i && out_last_i))
	else begin
		$error("done_o without a final word handshake");
		fail_cnt++;
	end

	parser_finished: assert property (@(posedge clk) disable iff (rst_i)
		done_i |-> parser_state_i == snappy_pkg::PS_DONE)
	else begin
		$error("page done while the token parser was still busy");
		fail_cnt++;
	end

	idle_after_reset: assert property (@(posedge clk)
		rst_i |=> !out_valid_i && !out_last_i && !done_i && in_ready_i)
	else begin
		$error("outputs not idle after reset");
		fail_cnt++;
	end

endmodule

`default_nettype wire

// File: sim/tb_decompressor.sv
//######################################################################
// testbench for the decompressor
// builds token pages, streams them in with random gaps and stalls
// and checks every output word against the expected bytes
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module tb_decompressor;

	localparam logic [31:0] SEED       = 32'h18a3b2d4;
	localparam int          FIFO_DEPTH = 16;
	localparam int          MAX_CYCLES = 20000;	// about 4x the worst case of all pages

	logic              clk = 1'b0;
	logic              rst_i;
	logic              start_i;
	snappy_pkg::len_t  compression_length_i;
	snappy_pkg::len_t  decompression_length_i;
	snappy_pkg::word_t data_i;
	logic              valid_i;
	logic              ready_o;
	snappy_pkg::word_t data_o;
	snappy_pkg::keep_t byte_valid_o;
	logic              valid_o;
	logic              ready_i;
	logic              last_o;
	logic              done_o;

	snappy_pkg::byte_t comp_bytes [$];	// tag stream of the page
	snappy_pkg::byte_t exp_bytes [$];	// bytes the page must decode to
	snappy_pkg::word_t in_words [$];
	logic [31:0]       page_seed;
	logic [31:0]       bus_seed;
	logic              stream_on;
	logic              gaps_en;
	logic              stalls_en;
	logic              xfer;
	int                word_pos;
	int                out_pos;
	int                done_cnt = 0;
	int                err_cnt = 0;
	int                test_cnt = 0;
	int                test_fails = 0;
	int                cycle_cnt = 0;

	decompressor #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_decompressor (
		.clk                    (clk),
		.rst_i                  (rst_i),
		.start_i                (start_i),
		.compression_length_i   (compression_length_i),
		.decompression_length_i (decompression_length_i),
		.data_i                 (data_i),
		.valid_i                (valid_i),
		.ready_o                (ready_o),
		.data_o                 (data_o),
		.byte_valid_o           (byte_valid_o),
		.valid_o                (valid_o),
		.ready_i                (ready_i),
		.last_o                 (last_o),
		.done_o                 (done_o)
	);

	bind decompressor decompressor_asserts #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_asserts (
		.clk            (clk),
		.rst_i          (rst_i),
		.in_ready_i     (ready_o),
		.out_valid_i    (valid_o),
		.out_ready_i    (ready_i),
		.out_data_i     (data_o),
		.out_keep_i     (byte_valid_o),
		.out_last_i     (last_o),
		.done_i         (done_o),
		.fifo_fill_i    (u_data_fifo.fill),
		.parser_state_i (u_token_parser.state)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned page_rand();
		page_seed = lcg_step(page_seed);
		return page_seed[31:8];
	endfunction

	function automatic int unsigned bus_rand();
		bus_seed = lcg_step(bus_seed);
		return bus_seed[31:8];
	endfunction

	function automatic int total_errors();
		return err_cnt + u_decompressor.u_asserts.fail_cnt;
	endfunction

	task automatic clear_page();
		comp_bytes.delete();
		exp_bytes.delete();
	endtask

	// base below zero gives random bytes
	task automatic add_literal(input int n, input int base);
		snappy_pkg::byte_t b;
		comp_bytes.push_back({6'(n - 1), snappy_pkg::TAG_LITERAL});
		for (int i = 0; i < n; i++) begin
			b = (base < 0) ? 8'(page_rand()) : 8'(base + i);
			comp_bytes.push_back(b);
			exp_bytes.push_back(b);
		end
	endtask

	// one byte per step, so overlapping copies repeat their pattern
	task automatic repeat_history(input int off, input int len);
		for (int i = 0; i < len; i++)
			exp_bytes.push_back(exp_bytes[exp_bytes.size() - off]);
	endtask

	task automatic add_copy1(input int off, input int len);
		comp_bytes.push_back({3'(off >> 8), 3'(len - 4), snappy_pkg::TAG_COPY1});
		comp_bytes.push_back(8'(off));
		repeat_history(off, len);
	endtask

	task automatic add_copy2(input int off, input int len);
		comp_bytes.push_back({6'(len - 1), snappy_pkg::TAG_COPY2});
		comp_bytes.push_back(8'(off));	// low byte first
		comp_bytes.push_back(8'(off >> 8));
		repeat_history(off, len);
	endtask

	// offsets stay inside the page, far below the history size
	task automatic add_random_page(input int target);
		int kind;
		int avail;
		add_literal(1 + page_rand() % 16, -1);
		while (exp_bytes.size() < target) begin
			kind  = page_rand() % 3;
			avail = exp_bytes.size();
			if (kind == 0)
				add_literal(1 + page_rand() % 16, -1);
			else if (kind == 1)
				add_copy1(1 + page_rand() % ((avail < 2047) ? avail : 2047), 4 + page_rand() % 8);
			else
				add_copy2(1 + page_rand() % avail, 1 + page_rand() % 64);
		end
	endtask

	task automatic pack_words();
		snappy_pkg::word_t w;
		int                idx;
		in_words.delete();
		for (int base = 0; base < comp_bytes.size(); base += snappy_pkg::WORD_BYTES) begin
			for (int lane = 0; lane < snappy_pkg::WORD_BYTES; lane++) begin
				idx = base + lane;
				// padding past the compressed length is random
				w[lane*8 +: 8] = (idx < comp_bytes.size()) ? comp_bytes[idx] : 8'(page_rand());
			end
			in_words.push_back(w);
		end
	endtask

	task automatic expect_bit(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			$display("Fail %s expected %h got %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic check_idle();
		expect_bit("valid_o", valid_o, 1'b0);
		expect_bit("last_o", last_o, 1'b0);
		expect_bit("done_o", done_o, 1'b0);
		expect_bit("ready_o", ready_o, 1'b1);
	endtask

	task automatic run_page(input logic gaps, input logic stalls);
		int base_done;
		pack_words();
		@(negedge clk);
		check_idle();
		word_pos               = 0;
		out_pos                = 0;
		gaps_en                = gaps;
		stalls_en              = stalls;
		compression_length_i   = comp_bytes.size();
		decompression_length_i = exp_bytes.size();
		base_done              = done_cnt;
		start_i                = 1'b1;
		stream_on <= 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		wait (done_cnt != base_done);
		@(negedge clk);
		stream_on <= 1'b0;
		repeat (2) @(negedge clk);
		assert (done_cnt == base_done + 1) else begin
			$display("done_o pulsed %0d times for one page", done_cnt - base_done);
			err_cnt++;
		end
		assert (out_pos == exp_bytes.size()) else begin
			$display("page ended after %0d of %0d bytes", out_pos, exp_bytes.size());
			err_cnt++;
		end
		check_idle();
	endtask

	task automatic report_test(input string name, input int mark);
		test_cnt++;
		if (total_errors() == mark) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, total_errors() - mark);
			test_fails++;
		end
	endtask

	always @(posedge clk) begin
		xfer = valid_i && ready_o;
		if (xfer)
			word_pos++;
	end

	// input bus and ready_i driver
	always @(negedge clk) begin
		if (!stream_on) begin
			valid_i = 1'b0;
			ready_i = 1'b1;
		end else begin
			if (!valid_i || xfer) begin	// hold until taken
				if (word_pos < in_words.size() && (!gaps_en || bus_rand() % 4 != 0)) begin
					valid_i = 1'b1;
					data_i  = in_words[word_pos];
				end else begin
					valid_i = 1'b0;
				end
			end
			ready_i = stalls_en ? bus_rand() % 2 : 1'b1;
		end
		xfer = 1'b0;
	end

	always @(posedge clk) begin : out_monitor
		snappy_pkg::word_t exp_word;
		snappy_pkg::word_t lane_mask;
		snappy_pkg::keep_t exp_keep;
		logic              exp_last;
		int                n;
		if (done_o)
			done_cnt++;
		if (valid_o && ready_i) begin
			exp_word  = '0;
			lane_mask = '0;
			exp_keep  = '0;
			n         = exp_bytes.size() - out_pos;
			if (n > snappy_pkg::WORD_BYTES)
				n = snappy_pkg::WORD_BYTES;
			if (n < 0)
				n = 0;
			for (int i = 0; i < n; i++) begin
				exp_word[i*8 +: 8]  = exp_bytes[out_pos + i];
				lane_mask[i*8 +: 8] = 8'hff;
				exp_keep[i]         = 1'b1;
			end
			exp_last = (out_pos + n == exp_bytes.size());
			assert (byte_valid_o == exp_keep) else begin
				$display("Fail byte_valid_o expected %h got %h", exp_keep, byte_valid_o);
				err_cnt++;
			end
			assert ((data_o & lane_mask) == exp_word) else begin
				$display("Fail data_o expected %h got %h", exp_word, data_o & lane_mask);
				err_cnt++;
			end
			assert (last_o == exp_last) else begin
				$display("Fail last_o expected %h got %h", exp_last, last_o);
				err_cnt++;
			end
			out_pos += n;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a page never completed", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin : main
		int mark;
		rst_i                  = 1'b1;
		start_i                = 1'b0;
		compression_length_i   = '0;
		decompression_length_i = '0;
		data_i                 = '0;
		valid_i                = 1'b0;
		ready_i                = 1'b1;
		stream_on              = 1'b0;
		gaps_en                = 1'b0;
		stalls_en              = 1'b0;
		xfer                   = 1'b0;
		word_pos               = 0;
		out_pos                = 0;
		page_seed              = SEED;
		bus_seed               = lcg_step(SEED);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		mark = total_errors();
		check_idle();
		report_test("reset state", mark);

		mark = total_errors();
		clear_page();
		add_literal(12, -1);
		add_literal(8, -1);	// 20 bytes, last word has 4 lanes
		run_page(1'b0, 1'b0);
		report_test("literals only", mark);

		mark = total_errors();
		clear_page();
		add_literal(2, 'h61);
		add_copy1(2, 10);
		add_copy1(1, 7);
		run_page(1'b0, 1'b0);
		report_test("overlapping copies", mark);

		mark = total_errors();
		clear_page();
		repeat (16) add_literal(64, -1);
		add_copy2(1000, 40);	// 1043 input bytes, 5 padding bytes
		run_page(1'b1, 1'b0);
		report_test("far copy and padding", mark);

		mark = total_errors();
		repeat (3) begin
			clear_page();
			add_random_page(160);
			run_page(1'b1, 1'b1);
		end
		report_test("random pages with stalls", mark);

		mark = total_errors();
		clear_page();
		add_literal(16, -1);
		add_copy2(16, 8);	// full final word
		run_page(1'b0, 1'b1);
		report_test("end of page", mark);

		mark = total_errors();
		clear_page();
		add_random_page(40);
		run_page(1'b1, 1'b0);
		clear_page();
		add_random_page(40);
		run_page(1'b0, 1'b0);
		report_test("back to back pages", mark);

		$display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
			test_cnt, test_fails, err_cnt, u_decompressor.u_asserts.fail_cnt);
		if (total_errors() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/snappy_pkg.sv
common/copy_cmd_if.sv
rtl/data_fifo.sv
parser/token_parser.sv
history/history_copier.sv
rtl/output_packer.sv
rtl/decompressor.sv
sim/decompressor_asserts.sv
sim/tb_decompressor.sv
